// ==== vlog.f ====
rtl/irq_pkg.sv
rtl/link_pkg.sv
rtl/irq_intake_if.sv
rtl/irq_intake.sv
rtl/irq_core.sv
rtl/vector_out.sv
rtl/irq_unit.sv
test/tb_clk_gen.sv
test/tb_irq_unit.sv

// ==== test/tb_irq_unit.sv ====
// ####################
// interrupt unit testbench
// random commands, channels, lines and credit returns
// checked against a model of rz, rm, rp and credits
// ####################

`timescale 1ns/100ps

module tb_irq_unit;
	import irq_pkg::*;
	import link_pkg::*;

	logic __clk;
	logic arst_n;
	logic cmd_valid;
	irq_op_t cmd_op;
	logic [15:0] cmd_data;
	logic [11:0] ext_irq;
	logic chan_valid;
	logic [3:0] chan_num;
	logic [15:0] rz;
	logic [9:0] rs;
	logic irq;
	logic vec_valid;
	logic [4:0] vec_num;
	logic vec_credit;

	logic [31:0] m_rz; // model requests
	logic [9:0] m_rm; // model mask
	logic [31:0] m_rp; // model in service
	int m_cred; // model credits
	integer seed;
	int k;
	logic [2:0] r_op;

	tb_clk_gen clk_gen_inst (.__clk(__clk), .arst_n(arst_n));

	irq_unit irq_unit_inst (
		.__clk(__clk), .arst_n(arst_n),
		.cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_data(cmd_data),
		.ext_irq(ext_irq), .chan_valid(chan_valid), .chan_num(chan_num),
		.rz(rz), .rs(rs), .irq(irq),
		.vec_valid(vec_valid), .vec_num(vec_num), .vec_credit(vec_credit)
	);

	// sources the mask groups let through
	function automatic logic [31:0] enabled(input logic [9:0] m);
		logic [31:0] e;
		e = 32'h1; // power failure
		for (int g = 0; g < 4; g++) begin
			if (m[g]) begin
				e[g + 1] = 1'b1; // one line per group
			end
		end
		if (m[4]) e[11:5] = '1;
		if (m[5]) e[13:12] = '1;
		if (m[6]) e[15:14] = '1;
		if (m[7]) e[21:16] = '1;
		if (m[8]) e[27:22] = '1;
		if (m[9]) e[31:28] = '1; // software sources
		return e;
	endfunction

	// user word to sources and back with channels hidden
	function automatic logic [31:0] word_to_src(input logic [15:0] w);
		return {w[15:12], 16'h0, w[11:0]};
	endfunction

	function automatic logic [15:0] src_to_word(input logic [31:0] s);
		return {s[31:28], s[11:0]};
	endfunction

	function automatic int lowest_rp();
		int lo;
		lo = 32; // nothing in service
		for (int i = 31; i >= 0; i--) begin
			if (m_rp[i]) lo = i;
		end
		return lo;
	endfunction

	// next vector by priority and nesting or -1 when none
	function automatic int next_vec();
		int v;
		logic [31:0] p;
		v = -1;
		p = m_rz & enabled(m_rm);
		for (int i = lowest_rp() - 1; i >= 0; i--) begin
			if (p[i]) v = i;
		end
		return v;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic take_vector();
		int v;
		v = next_vec();
		if (v < 0 || m_cred == 0) begin
			abort_run("a vector came out while nothing was deliverable");
		end
		check_val("vec_num", vec_num, v);
		m_rz[v] = 1'b0; // request moves to service
		m_rp[v] = 1'b1;
		m_cred--;
	endtask

	// one clock that catches any vector on the link
	task automatic step();
		@(negedge __clk);
		if (vec_valid) take_vector();
	endtask

	// run until the model expects no more vectors and then compare status
	task automatic settle();
		int quiet;
		int cyc;
		quiet = 0;
		cyc = 0;
		while (quiet < 8 || (next_vec() >= 0 && m_cred > 0)) begin
			step();
			cyc++;
			if (vec_valid) quiet = 0;
			else quiet++;
			if (cyc > 200) abort_run("timeout waiting for an expected vector");
		end
		check_val("rz", rz, src_to_word(m_rz));
		check_val("rs", rs, m_rm);
		check_val("irq", irq, |(m_rz & enabled(m_rm))); // nesting ignored
	endtask

	task automatic send_cmd(input irq_op_t op, input logic [15:0] data);
		int lo;
		step();
		cmd_valid = 1'b1;
		cmd_op = op;
		cmd_data = data;
		step();
		cmd_valid = 1'b0;
		cmd_op = op_none;
		lo = lowest_rp();
		case (op)
			op_set_req: m_rz = m_rz | word_to_src(data);
			op_clr_req: m_rz = m_rz & ~word_to_src(data);
			op_set_mask: m_rm = data[9:0];
			op_end_service: if (lo < 32) m_rp[lo] = 1'b0; // innermost only
			default: ;
		endcase
		settle();
	endtask

	task automatic send_chan(input logic [3:0] n);
		step();
		chan_valid = 1'b1;
		chan_num = n;
		step();
		chan_valid = 1'b0;
		m_rz[12 + int'(n)] = 1'b1;
		settle();
	endtask

	task automatic set_ext(input logic [11:0] v);
		step();
		m_rz[11:0] = m_rz[11:0] | (v & ~ext_irq); // rising lines only
		ext_irq = v;
		settle();
	endtask

	task automatic return_credit(input int delay);
		for (int i = 0; i < delay; i++) step();
		if (m_cred < credit_max) begin
			step();
			vec_credit = 1'b1;
			step();
			vec_credit = 1'b0;
			m_cred++;
			settle();
		end
	endtask

	// end services and return credits until idle
	task automatic drain();
		int n;
		n = 0;
		while (m_rp != 0 || next_vec() >= 0 || m_cred < credit_max) begin
			if (m_cred < credit_max) return_credit(1);
			else send_cmd(op_end_service, 16'h0);
			n++;
			if (n > 200) abort_run("pending requests never drained");
		end
	endtask

	task automatic wait_reset();
		int cyc;
		cyc = 0;
		while (arst_n !== 1'b1) begin
			@(posedge __clk); // reset lifts on a falling edge
			cyc++;
			if (cyc > 50) abort_run("reset was never released");
		end
		@(negedge __clk);
	endtask

	initial begin
		seed = 6;
		cmd_valid = 1'b0;
		cmd_op = op_none;
		cmd_data = '0;
		ext_irq = '0;
		chan_valid = 1'b0;
		chan_num = '0;
		vec_credit = 1'b0;
		m_rz = '0;
		m_rm = '0;
		m_rp = '0;
		m_cred = credit_max;
		wait_reset();
		check_val("vec_valid", vec_valid, 1'b0);
		check_val("irq", irq, 1'b0);
		settle(); // rz and rs zero
		// descending sources nest until the credits run out
		send_cmd(op_set_mask, 16'h03ff);
		for (int s = 11; s >= 8; s--) send_cmd(op_set_req, 16'h1 << s);
		send_cmd(op_set_req, 16'h0080); // source 7 waits for a credit
		return_credit(3);
		drain();
		send_cmd(op_set_req, 16'h0228); // 3 then 5 then 9 with one per eoi
		drain();
		// under a zero mask only power failure gets through
		send_cmd(op_set_mask, 16'h0);
		send_cmd(op_set_req, 16'hfffe);
		send_cmd(op_set_req, 16'h0001);
		drain();
		send_cmd(op_set_mask, $random(seed));
		drain();
		// readback of random set and clear
		send_cmd(op_set_mask, 16'h0);
		repeat (20) send_cmd(($random(seed) & 1) ? op_set_req : op_clr_req, $random(seed));
		drain();
		// line edge and clear meet in one update where the set must win
		k = 1 + {$random(seed)} % 11;
		step();
		ext_irq[k] = 1'b1;
		step();
		step();
		cmd_valid = 1'b1;
		cmd_op = op_clr_req;
		cmd_data = 16'hffff;
		step();
		cmd_valid = 1'b0;
		cmd_op = op_none;
		m_rz = m_rz & ~word_to_src(16'hffff);
		m_rz[k] = 1'b1;
		settle();
		set_ext(12'h0);
		// channels and held lines with everything enabled
		send_cmd(op_set_mask, 16'h03ff);
		drain();
		repeat (4) begin
			send_chan($random(seed));
			drain();
		end
		repeat (4) begin
			k = {$random(seed)} % 12;
			set_ext(12'h1 << k);
			drain();
			settle(); // line still high so no second vector
			set_ext(12'h0);
		end
		// random mix
		repeat (150) begin
			case ({$random(seed)} % 6)
				0: begin
					r_op = {$random(seed)} % 5;
					send_cmd(irq_op_t'(r_op), $random(seed));
				end
				1: send_chan($random(seed));
				2: set_ext(ext_irq ^ $random(seed));
				3: return_credit({$random(seed)} % 8);
				4: send_cmd(op_end_service, 16'h0);
				default: send_cmd(op_set_req, $random(seed));
			endcase
		end
		drain();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== test/tb_clk_gen.sv ====
// ####################
// testbench clock and reset
// 4 ns clock, reset held for 8 cycles
// ####################

`timescale 1ns/100ps

module tb_clk_gen (
	output logic __clk,
	output logic arst_n
);

	initial begin
		__clk = 1'b0;
		forever #2 __clk = ~__clk; // 4 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (8) @(posedge __clk);
		@(negedge __clk);
		arst_n = 1'b1; // release away from the rising edge
	end

endmodule

// ==== rtl/irq_unit.sv ====
// ####################
// interrupt unit top
// intake -> core -> vector link
// ####################

`timescale 1ns/100ps

module irq_unit (
	input __clk,
	input arst_n,
	// cpu commands
	input cmd_valid,
	input irq_pkg::irq_op_t cmd_op,
	input [irq_pkg::user_w-1:0] cmd_data,
	// request sources
	input [irq_pkg::n_ext-1:0] ext_irq,
	input chan_valid,
	input [irq_pkg::chan_w-1:0] chan_num,
	// status
	output [irq_pkg::user_w-1:0] rz,
	output [irq_pkg::n_grp-1:0] rs,
	output irq,
	// vector link
	output vec_valid,
	output [irq_pkg::src_w-1:0] vec_num,
	input vec_credit
);
	import irq_pkg::*;

	logic cand_valid; // core offers a source
	logic [src_w-1:0] cand_num;
	logic take; // accepted, credit available

	irq_intake_if upd_if ();

	irq_intake irq_intake_inst (
		.__clk(__clk),
		.arst_n(arst_n),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.cmd_data(cmd_data),
		.ext_irq(ext_irq),
		.chan_valid(chan_valid),
		.chan_num(chan_num),
		.upd(upd_if.intake)
	);

	irq_core irq_core_inst (
		.__clk(__clk),
		.arst_n(arst_n),
		.upd(upd_if.core),
		.take(take),
		.cand_valid(cand_valid),
		.cand_num(cand_num),
		.rz(rz),
		.rs(rs),
		.irq(irq)
	);

	vector_out vector_out_inst (
		.__clk(__clk),
		.arst_n(arst_n),
		.cand_valid(cand_valid),
		.cand_num(cand_num),
		.take(take),
		.vec_valid(vec_valid),
		.vec_num(vec_num),
		.vec_credit(vec_credit)
	);

endmodule

// ==== rtl/vector_out.sv ====
// ####################
// vector output
// credit counter for the consumer link,
// registers each taken source number
// ####################

`timescale 1ns/100ps

module vector_out (
	input __clk,
	input arst_n,
	input cand_valid,
	input [irq_pkg::src_w-1:0] cand_num,
	output logic take,
	output logic vec_valid,
	output logic [irq_pkg::src_w-1:0] vec_num,
	input vec_credit
);
	import link_pkg::*;

	credit_t credits; // consumer slots left

	// no take in the cycle after a take, rp needs that cycle
	assign take = cand_valid && (credits != '0) && !vec_valid;

	// vec_valid spends, vec_credit returns
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			credits <= credit_max;
			vec_valid <= 1'b0;
		end else begin
			vec_valid <= take;
			case ({vec_valid, vec_credit})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ; // both or neither, no change
			endcase
		end
	end

	// vector number, qualified by vec_valid
	always_ff @(posedge __clk) begin
		if (take) begin
			vec_num <= cand_num;
		end
	end

	// consumer returned more than it was given
	a_credit_max: assert property (@(posedge __clk) disable iff (!arst_n)
		credits <= credit_max)
		else $error("credit counter above credit_max");

	a_no_overrun: assert property (@(posedge __clk) disable iff (!arst_n)
		vec_valid |-> (credits != '0))
		else $error("vector sent without a credit");

endmodule

// ==== rtl/irq_core.sv ====
// ####################
// interrupt core
// rz requests, rm group mask, rp in service
// picks the highest priority deliverable source,
// nesting only above the lowest rp bit
// ####################

`timescale 1ns/100ps

module irq_core (
	input __clk,
	input arst_n,
	irq_intake_if.core upd,
	input take,
	output logic cand_valid,
	output logic [irq_pkg::src_w-1:0] cand_num,
	output logic [irq_pkg::user_w-1:0] rz,
	output logic [irq_pkg::n_grp-1:0] rs,
	output logic irq
);
	import irq_pkg::*;

	logic [n_src-1:0] rz_q; // request register
	logic [n_grp-1:0] rm_q; // group mask
	logic [n_src-1:0] rp_q; // in service
	logic [n_src-1:0] rm_en; // mask expanded to sources
	logic [n_src-1:0] pend; // requested and enabled
	logic [n_src-1:0] rp_lo; // lowest rp bit, one-hot
	logic [n_src-1:0] allow; // sources that may nest
	logic [n_src-1:0] elig;
	logic [n_src-1:0] cand_oh;
	logic [n_src-1:0] take_oh;
	logic [n_src-1:0] eoi_oh;

	// group mask expansion
	always_comb begin
		rm_en = nmi_mask; // source 0 always
		for (int g = 0; g < n_grp; g++) begin
			if (rm_q[g]) begin
				rm_en = rm_en | grp_map[g];
			end
		end
	end

	assign pend = rz_q & rm_en;

	// x & -x keeps the lowest set bit
	assign rp_lo = rp_q & (~rp_q + 1'b1);
	// bits below rp_lo; empty rp wraps to all ones
	assign allow = rp_lo - 1'b1;

	assign elig = pend & allow;
	assign cand_oh = elig & (~elig + 1'b1); // lowest number wins
	assign cand_valid = |elig;

	// one-hot to number
	always_comb begin
		cand_num = '0;
		for (int i = 0; i < n_src; i++) begin
			if (cand_oh[i]) begin
				cand_num = src_w'(i);
			end
		end
	end

	assign take_oh = take ? cand_oh : '0;
	assign eoi_oh = upd.eoi ? rp_lo : '0; // ends the innermost service

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			rz_q <= '0;
			rm_q <= '0;
			rp_q <= '0;
		end else begin
			// set wins over clear and over take
			rz_q <= (rz_q & ~upd.req_clr & ~take_oh) | upd.req_set;
			rp_q <= (rp_q & ~eoi_oh) | take_oh; // take is always below rp_lo
			if (upd.mask_wr) begin
				rm_q <= upd.mask_data;
			end
		end
	end

	// status to the cpu
	assign rz = user_pick(rz_q);
	assign rs = rm_q;
	assign irq = |pend; // ignores nesting

	// vector_out may only take what is offered
	a_take_cand: assert property (@(posedge __clk) disable iff (!arst_n)
		take |-> cand_valid)
		else $error("take without a candidate");

	// a new rp bit is always of higher priority than the old innermost one
	a_nest: assert property (@(posedge __clk) disable iff (!arst_n)
		((rp_q & ~$past(rp_q)) & ~($past(rp_lo) - 1'b1)) == '0)
		else $error("rp gained a bit at or below the lowest in service");

endmodule

// ==== rtl/irq_intake.sv ====
// ####################
// interrupt intake
// syncs external lines and catches rising edges,
// decodes channel messages and cpu commands
// into one registered update per cycle
// ####################

`timescale 1ns/100ps

module irq_intake (
	input __clk,
	input arst_n,
	input cmd_valid,
	input irq_pkg::irq_op_t cmd_op,
	input [irq_pkg::user_w-1:0] cmd_data,
	input [irq_pkg::n_ext-1:0] ext_irq,
	input chan_valid,
	input [irq_pkg::chan_w-1:0] chan_num,
	irq_intake_if.intake upd
);
	import irq_pkg::*;

	logic [n_ext-1:0] ext_s1; // first sync stage
	logic [n_ext-1:0] ext_s2; // second sync stage
	logic [n_ext-1:0] ext_d; // edge flop
	logic [n_ext-1:0] ext_rise;
	logic [n_src-1:0] chan_bit;
	logic [n_src-1:0] set_d;
	logic [n_src-1:0] clr_d;
	logic mask_d;
	logic eoi_d;

	// line went 0 -> 1, a held line fires once
	assign ext_rise = ext_s2 & ~ext_d;

	// channel n -> source chan_base + n
	always_comb begin
		chan_bit = '0;
		if (chan_valid) begin
			chan_bit[chan_base + int'(chan_num)] = 1'b1;
		end
	end

	// command decode
	always_comb begin
		set_d = {{(n_src - n_ext){1'b0}}, ext_rise} | chan_bit;
		clr_d = '0;
		mask_d = 1'b0;
		eoi_d = 1'b0;
		if (cmd_valid) begin
			case (cmd_op)
				op_set_req: set_d = set_d | user_map(cmd_data);
				op_clr_req: clr_d = user_map(cmd_data); // core lets sets win
				op_set_mask: mask_d = 1'b1;
				op_end_service: eoi_d = 1'b1;
				default: ; // op_none
			endcase
		end
	end

	// synchronizer and edge detect
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			ext_s1 <= '0;
			ext_s2 <= '0;
			ext_d <= '0;
		end else begin
			ext_s1 <= ext_irq; // async lines
			ext_s2 <= ext_s1;
			ext_d <= ext_s2;
		end
	end

	// update strobes, valid for one cycle
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			upd.req_set <= '0;
			upd.req_clr <= '0;
			upd.mask_wr <= 1'b0;
			upd.eoi <= 1'b0;
		end else begin
			upd.req_set <= set_d;
			upd.req_clr <= clr_d;
			upd.mask_wr <= mask_d;
			upd.eoi <= eoi_d;
		end
	end

	// new mask word, qualified by mask_wr
	always_ff @(posedge __clk) begin
		if (mask_d) begin
			upd.mask_data <= cmd_data[n_grp-1:0];
		end
	end

	a_one_ctl: assert property (@(posedge __clk) disable iff (!arst_n)
		!(upd.eoi && upd.mask_wr))
		else $error("eoi and mask write in one update");

endmodule

// ==== rtl/irq_intake_if.sv ====
// ####################
// intake to core update bus
// one-cycle register updates, no handshake
// ####################

`timescale 1ns/100ps

interface irq_intake_if;
	import irq_pkg::*;

	logic [n_src-1:0] req_set; // rz bits to set
	logic [n_src-1:0] req_clr; // rz bits to clear, set wins
	logic mask_wr; // load rm
	logic [n_grp-1:0] mask_data;
	logic eoi; // end of service, drop lowest rp bit

	modport intake (
		output req_set,
		output req_clr,
		output mask_wr,
		output mask_data,
		output eoi
	);

	modport core (
		input req_set,
		input req_clr,
		input mask_wr,
		input mask_data,
		input eoi
	);

endinterface

// ==== rtl/link_pkg.sv ====
// ####################
// vector link definitions
// credit count granted by the consumer
// and the counter width
// ####################

package link_pkg;

	localparam int credit_w = 3; // holds 0..credit_max

	// credits granted after reset
	localparam logic [credit_w-1:0] credit_max = 3'd4;

	typedef logic [credit_w-1:0] credit_t;

endpackage

// ==== rtl/irq_pkg.sv ====
// ####################
// interrupt unit definitions
// source numbering, mask groups, command opcodes
// and the user word layout of rz
// ####################

package irq_pkg;

	localparam int n_src = 32; // one word of sources
	localparam int src_w = 5;
	localparam int n_grp = 10; // mask groups in rm
	localparam int n_ext = 12; // external lines, sources 0..11
	localparam int n_sw = 4; // software sources
	localparam int chan_w = 4; // channel number width
	localparam int chan_base = 12; // first i/o channel source
	localparam int sw_base = 28; // first software source
	localparam int user_w = n_ext + n_sw; // 16-bit user word

	// power failure, never masked
	localparam logic [n_src-1:0] nmi_mask = 32'h0000_0001;

	// sources enabled by each rm bit
	localparam logic [n_src-1:0] grp_map [n_grp] = '{
		32'h0000_0002, // g0: 1
		32'h0000_0004, // g1: 2
		32'h0000_0008, // g2: 3
		32'h0000_0010, // g3: 4
		32'h0000_0fe0, // g4: 5..11
		32'h0000_3000, // g5: 12..13
		32'h0000_c000, // g6: 14..15
		32'h003f_0000, // g7: 16..21
		32'h0fc0_0000, // g8: 22..27
		32'hf000_0000  // g9: 28..31
	};

	typedef enum logic [2:0] {
		op_none        = 3'd0,
		op_set_mask    = 3'd1,
		op_set_req     = 3'd2,
		op_clr_req     = 3'd3,
		op_end_service = 3'd4
	} irq_op_t;

	// user bits 0..11 -> sources 0..11, bits 12..15 -> 28..31
	function automatic logic [n_src-1:0] user_map(input logic [user_w-1:0] w);
		logic [n_src-1:0] s;
		s = '0;
		s[n_ext-1:0] = w[n_ext-1:0];
		s[sw_base +: n_sw] = w[user_w-1 -: n_sw];
		return s;
	endfunction

	// reverse of user_map, channel sources are not visible
	function automatic logic [user_w-1:0] user_pick(input logic [n_src-1:0] s);
		return {s[sw_base +: n_sw], s[n_ext-1:0]};
	endfunction

endpackage
